/* source/apb_bus_pkg.sv */
`default_nettype none

package apb_bus_pkg;

  // ----------------------------------------
  // Bus widths
  // ----------------------------------------
  localparam int addr_width = 16;
  localparam int data_width = 32;

  // Register word offset, address bits 11 to 2
  typedef logic [9:0] word_addr_t;

  typedef logic [data_width-1:0] apb_data_t;

  // ----------------------------------------
  // Slot numbering
  // ----------------------------------------
  // Upper address nibble selects the slot
  typedef enum logic [3:0] {
    slot_uart  = 4'd0,
    slot_timer = 4'd1
  } slot_e;                                // All other nibbles unmapped

  // ----------------------------------------
  // Interrupt vector
  // ----------------------------------------
  localparam int irq_width     = 32;
  localparam int irq_tx_bit    = 1;        // UART transmit
  localparam int irq_timer_bit = 8;        // Down-counter expiry

endpackage

`default_nettype wire

/* source/periph_regs_pkg.sv */
`default_nettype none

package periph_regs_pkg;

  // ----------------------------------------
  // Timer register map
  // ----------------------------------------
  typedef enum logic [9:0] {
    timer_ctrl      = 10'd0,
    timer_value     = 10'd1,
    timer_reload    = 10'd2,
    timer_intstatus = 10'd3
  } timer_reg_e;

  localparam int timer_en_bit     = 0;
  localparam int timer_irq_en_bit = 3;

  // ----------------------------------------
  // UART register map
  // ----------------------------------------
  typedef enum logic [9:0] {
    uart_data      = 10'd0,
    uart_state     = 10'd1,
    uart_ctrl      = 10'd2,
    uart_intstatus = 10'd3,
    uart_bauddiv   = 10'd4
  } uart_reg_e;

  // Transmit frame phases
  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;

  localparam int uart_tx_irq_en_bit = 2;
  localparam int bauddiv_width      = 20;
  localparam int bauddiv_reset      = 16;   // Cycles per bit out of reset

endpackage

`default_nettype wire

/* source/apb_slot_if.sv */
`timescale 1ns/100ps
`default_nettype none

// One APB completer slot behind the address decoder
interface apb_slot_if;

  // Request, from the decoder
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  apb_bus_pkg::word_addr_t addr;
  apb_bus_pkg::apb_data_t  wdata;

  // Response, from the peripheral
  apb_bus_pkg::apb_data_t  rdata;
  logic                    ready;
  logic                    slverr;

  modport decoder (
    output psel, penable, pwrite, addr, wdata,
    input  rdata, ready, slverr
  );

  modport peripheral (
    input  psel, penable, pwrite, addr, wdata,
    output rdata, ready, slverr
  );

endinterface

`default_nettype wire

/* source/apb_slot_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_slot_decoder (
  input  wire [apb_bus_pkg::addr_width-1:0] paddr,
  input  wire                               psel,
  input  wire                               penable,
  input  wire                               pwrite,
  input  wire apb_bus_pkg::apb_data_t       pwdata,
  output apb_bus_pkg::apb_data_t            prdata,
  output logic                              pready,
  output logic                              pslverr,
  apb_slot_if.decoder                       uart_slot,
  apb_slot_if.decoder                       timer_slot
);

  apb_bus_pkg::slot_e      slot;
  apb_bus_pkg::word_addr_t word_addr;

  assign slot      = apb_bus_pkg::slot_e'(paddr[apb_bus_pkg::addr_width-1 -: 4]);
  assign word_addr = paddr[11:2];

  // ----------------------------------------
  // Per-slot selects
  // ----------------------------------------
  assign uart_slot.psel  = psel && (slot == apb_bus_pkg::slot_uart);
  assign timer_slot.psel = psel && (slot == apb_bus_pkg::slot_timer);

  // Shared request fields go to every slot
  assign uart_slot.penable  = penable;
  assign uart_slot.pwrite   = pwrite;
  assign uart_slot.addr     = word_addr;
  assign uart_slot.wdata    = pwdata;

  assign timer_slot.penable = penable;
  assign timer_slot.pwrite  = pwrite;
  assign timer_slot.addr    = word_addr;
  assign timer_slot.wdata   = pwdata;

  // ----------------------------------------
  // Response return
  // ----------------------------------------
  always_comb begin
    case (slot)
      apb_bus_pkg::slot_uart: begin
        prdata  = uart_slot.rdata;
        pready  = uart_slot.ready;
        pslverr = uart_slot.slverr;
      end
      apb_bus_pkg::slot_timer: begin
        prdata  = timer_slot.rdata;
        pready  = timer_slot.ready;
        pslverr = timer_slot.slverr;
      end
      default: begin
        // Unmapped slot, error with no wait states
        prdata  = '0;
        pready  = 1'b1;
        pslverr = psel && penable;  // Only in the access cycle
      end
    endcase
  end

endmodule

`default_nettype wire

/* source/apb_timer.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_timer #(
  parameter int timer_width = 32
) (
  input  wire            HCLK,
  input  wire            sysrst,
  apb_slot_if.peripheral bus,
  output logic           timer_int
);

  logic [3:0]             ctrl_q;
  logic [timer_width-1:0] value_q;
  logic [timer_width-1:0] reload_q;
  logic                   intstatus_q;

  logic                        wr_en;
  logic                        rd_en;
  logic                        expire;
  periph_regs_pkg::timer_reg_e reg_sel;

  assign reg_sel = periph_regs_pkg::timer_reg_e'(bus.addr);
  assign wr_en   = bus.psel && bus.penable && bus.pwrite;
  assign rd_en   = bus.psel && bus.penable && !bus.pwrite;

  // Counter reaches zero while running
  assign expire = ctrl_q[periph_regs_pkg::timer_en_bit] && (value_q == '0);

  // ----------------------------------------
  // Register file and counter
  // ----------------------------------------
  always_ff @(posedge HCLK or negedge sysrst) begin
    if (!sysrst) begin
      ctrl_q      <= '0;
      value_q     <= '0;
      reload_q    <= '0;
      intstatus_q <= 1'b0;
    end else begin
      if (wr_en && reg_sel == periph_regs_pkg::timer_ctrl)
        ctrl_q <= bus.wdata[3:0];

      if (wr_en && reg_sel == periph_regs_pkg::timer_reload)
        reload_q <= bus.wdata[timer_width-1:0];

      // Bus write wins over counting
      if (wr_en && reg_sel == periph_regs_pkg::timer_value) begin
        value_q <= bus.wdata[timer_width-1:0];
      end else if (expire) begin
        value_q <= reload_q;
      end else if (ctrl_q[periph_regs_pkg::timer_en_bit]) begin
        value_q <= value_q - 1'b1;
      end

      if (expire)
        intstatus_q <= 1'b1;                 // Set beats clear
      else if (wr_en && reg_sel == periph_regs_pkg::timer_intstatus && bus.wdata[0])
        intstatus_q <= 1'b0;                 // Write 1 to clear
    end
  end

  assign timer_int = intstatus_q && ctrl_q[periph_regs_pkg::timer_irq_en_bit];

  // ----------------------------------------
  // Read back
  // ----------------------------------------
  always_comb begin
    bus.rdata = '0;
    if (rd_en) begin
      case (reg_sel)
        periph_regs_pkg::timer_ctrl:      bus.rdata = apb_bus_pkg::apb_data_t'(ctrl_q);
        periph_regs_pkg::timer_value:     bus.rdata = apb_bus_pkg::apb_data_t'(value_q);
        periph_regs_pkg::timer_reload:    bus.rdata = apb_bus_pkg::apb_data_t'(reload_q);
        periph_regs_pkg::timer_intstatus: bus.rdata = apb_bus_pkg::apb_data_t'(intstatus_q);
        default:                          bus.rdata = '0;
      endcase
    end
  end

  assign bus.ready  = 1'b1;   // Zero wait states
  assign bus.slverr = 1'b0;

endmodule

`default_nettype wire

/* source/apb_uart_tx.sv */
`timescale 1ns/100ps
`default_nettype none

module apb_uart_tx (
  input  wire            HCLK,
  input  wire            sysrst,
  apb_slot_if.peripheral bus,
  output logic           txd,
  output logic           tx_int
);

  localparam int div_w = periph_regs_pkg::bauddiv_width;

  periph_regs_pkg::tx_state_e state_q;

  logic [7:0]       shift_q;      // Byte being sent, LSB first
  logic [div_w-1:0] baud_cnt;
  logic [2:0]       bit_cnt;
  logic [3:0]       ctrl_q;
  logic [div_w-1:0] bauddiv_q;
  logic             intstatus_q;

  logic                       wr_en;
  logic                       rd_en;
  logic                       busy;
  logic                       bit_end;
  logic                       frame_done;
  logic                       start_req;
  periph_regs_pkg::uart_reg_e reg_sel;

  assign reg_sel = periph_regs_pkg::uart_reg_e'(bus.addr);
  assign wr_en   = bus.psel && bus.penable && bus.pwrite;
  assign rd_en   = bus.psel && bus.penable && !bus.pwrite;

  assign busy      = (state_q != periph_regs_pkg::tx_idle);
  assign start_req = wr_en && (reg_sel == periph_regs_pkg::uart_data) && !busy;

  // A divisor of zero behaves as one
  assign bit_end    = (baud_cnt + 1'b1) >= bauddiv_q;
  assign frame_done = (state_q == periph_regs_pkg::tx_stop) && bit_end;

  // ----------------------------------------
  // Transmit FSM
  // ----------------------------------------
  always_ff @(posedge HCLK or negedge sysrst) begin
    if (!sysrst) begin
      state_q  <= periph_regs_pkg::tx_idle;
      shift_q  <= '0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
    end else begin
      case (state_q)
        periph_regs_pkg::tx_idle: begin
          if (start_req) begin
            shift_q  <= bus.wdata[7:0];
            baud_cnt <= '0;
            state_q  <= periph_regs_pkg::tx_start;
          end
        end
        periph_regs_pkg::tx_start: begin
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (bit_end) begin
            bit_cnt <= '0;
            state_q <= periph_regs_pkg::tx_data;
          end
        end
        periph_regs_pkg::tx_data: begin
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (bit_end) begin
            shift_q <= shift_q >> 1;
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7)
              state_q <= periph_regs_pkg::tx_stop;
          end
        end
        default: begin                       // Stop bit
          baud_cnt <= bit_end ? '0 : baud_cnt + 1'b1;
          if (bit_end)
            state_q <= periph_regs_pkg::tx_idle;
        end
      endcase
    end
  end

  always_comb begin
    case (state_q)
      periph_regs_pkg::tx_start: txd = 1'b0;
      periph_regs_pkg::tx_data:  txd = shift_q[0];
      default:                   txd = 1'b1;   // Idle line and stop bit
    endcase
  end

  // ----------------------------------------
  // Register file
  // ----------------------------------------
  always_ff @(posedge HCLK or negedge sysrst) begin
    if (!sysrst) begin
      ctrl_q      <= '0;
      bauddiv_q   <= div_w'(periph_regs_pkg::bauddiv_reset);
      intstatus_q <= 1'b0;
    end else begin
      if (wr_en && reg_sel == periph_regs_pkg::uart_ctrl)
        ctrl_q <= bus.wdata[3:0];
      if (wr_en && reg_sel == periph_regs_pkg::uart_bauddiv)
        bauddiv_q <= bus.wdata[div_w-1:0];
      if (frame_done)
        intstatus_q <= 1'b1;
      else if (wr_en && reg_sel == periph_regs_pkg::uart_intstatus && bus.wdata[0])
        intstatus_q <= 1'b0;
    end
  end

  assign tx_int = intstatus_q && ctrl_q[periph_regs_pkg::uart_tx_irq_en_bit];

  always_comb begin
    bus.rdata = '0;
    if (rd_en) begin
      case (reg_sel)
        periph_regs_pkg::uart_data:      bus.rdata = apb_bus_pkg::apb_data_t'(shift_q);
        periph_regs_pkg::uart_state:     bus.rdata = apb_bus_pkg::apb_data_t'(busy);
        periph_regs_pkg::uart_ctrl:      bus.rdata = apb_bus_pkg::apb_data_t'(ctrl_q);
        periph_regs_pkg::uart_intstatus: bus.rdata = apb_bus_pkg::apb_data_t'(intstatus_q);
        periph_regs_pkg::uart_bauddiv:   bus.rdata = apb_bus_pkg::apb_data_t'(bauddiv_q);
        default:                         bus.rdata = '0;
      endcase
    end
  end

  assign bus.ready  = 1'b1;
  assign bus.slverr = 1'b0;

endmodule

`default_nettype wire

/* source/mcu_periph_top.sv */
`timescale 1ns/100ps
`default_nettype none

module mcu_periph_top #(
  parameter int timer_width = 32
) (
  input  wire                                HCLK,
  input  wire                                sysrst,
  // APB completer
  input  wire [apb_bus_pkg::addr_width-1:0]  paddr,
  input  wire                                psel,
  input  wire                                penable,
  input  wire                                pwrite,
  input  wire apb_bus_pkg::apb_data_t        pwdata,
  output apb_bus_pkg::apb_data_t             prdata,
  output logic                               pready,
  output logic                               pslverr,
  // Serial line and interrupts
  output logic                               txd,
  output logic [apb_bus_pkg::irq_width-1:0]  irq
);

  logic tx_int;
  logic timer_int;

  apb_slot_if uart_slot ();
  apb_slot_if timer_slot ();

  apb_slot_decoder u_apb_slot_decoder (
    .paddr      (paddr),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .pready     (pready),
    .pslverr    (pslverr),
    .uart_slot  (uart_slot.decoder),
    .timer_slot (timer_slot.decoder)
  );

  apb_timer #(
    .timer_width (timer_width)
  ) u_apb_timer (
    .HCLK      (HCLK),
    .sysrst    (sysrst),
    .bus       (timer_slot.peripheral),
    .timer_int (timer_int)
  );

  apb_uart_tx u_apb_uart_tx (
    .HCLK   (HCLK),
    .sysrst (sysrst),
    .bus    (uart_slot.peripheral),
    .txd    (txd),
    .tx_int (tx_int)
  );

  // ----------------------------------------
  // Interrupt vector
  // ----------------------------------------
  always_comb begin
    irq = '0;                                  // Unused lines tied low
    irq[apb_bus_pkg::irq_tx_bit]    = tx_int;
    irq[apb_bus_pkg::irq_timer_bit] = timer_int;
  end

endmodule

`default_nettype wire

/* verification/mcu_periph_asserts.sv */
`timescale 1ns/100ps
`default_nettype none

module mcu_periph_asserts (
  input wire                              HCLK,
  input wire                              sysrst,
  input wire                              psel,
  input wire                              penable,
  input wire                              pready,
  input wire                              pslverr,
  input wire                              txd,
  input wire [apb_bus_pkg::irq_width-1:0] irq
);

  // Only UART transmit and timer lines may ever be high
  localparam logic [apb_bus_pkg::irq_width-1:0] irq_used =
    (1 << apb_bus_pkg::irq_tx_bit) | (1 << apb_bus_pkg::irq_timer_bit);

  int violations = 0;

  access_ready: assert property (@(posedge HCLK) disable iff (!sysrst)
    (psel && penable) |-> pready) else begin
    $error("pready low in an APB access cycle");
    violations++;
  end

  slverr_in_access: assert property (@(posedge HCLK) disable iff (!sysrst)
    pslverr |-> (psel && penable)) else begin
    $error("pslverr high outside an access cycle");
    violations++;
  end

  irq_unused_low: assert property (@(posedge HCLK) disable iff (!sysrst)
    (irq & ~irq_used) == '0) else begin
    $error("Unused irq line high");
    violations++;
  end

  // Frame done means the transmitter is back to idle
  txd_idle_high: assert property (@(posedge HCLK) disable iff (!sysrst)
    $rose(irq[apb_bus_pkg::irq_tx_bit]) |-> txd) else begin
    $error("txd low while the UART is idle");
    violations++;
  end

endmodule

bind mcu_periph_top mcu_periph_asserts u_mcu_periph_asserts (
  .HCLK (HCLK), .sysrst (sysrst), .psel (psel), .penable (penable), .pready (pready),
  .pslverr (pslverr), .txd (txd), .irq (irq)
);

`default_nettype wire

/* verification/mcu_periph_tb.sv */
`timescale 1ns/100ps
`default_nettype none

module mcu_periph_tb;

  localparam logic [15:0] uart_data_a    = 16'h0000;
  localparam logic [15:0] uart_state_a   = 16'h0004;
  localparam logic [15:0] uart_ctrl_a    = 16'h0008;
  localparam logic [15:0] uart_int_a     = 16'h000C;
  localparam logic [15:0] uart_baud_a    = 16'h0010;
  localparam logic [15:0] timer_ctrl_a   = 16'h1000;
  localparam logic [15:0] timer_value_a  = 16'h1004;
  localparam logic [15:0] timer_reload_a = 16'h1008;
  localparam logic [15:0] timer_int_a    = 16'h100C;
  localparam int          baud_div       = 4;    // Cycles per UART bit

  logic        HCLK, sysrst, psel, penable, pwrite, pready, pslverr, txd, last_err;
  logic [15:0] paddr;
  logic [31:0] pwdata, prdata, irq, rd, rng;
  logic [7:0]  b, got;
  logic        stop_bit;
  int          err_cnt, pass_cnt, fail_cnt;

  mcu_periph_top u_mcu_periph_top (
    .HCLK (HCLK), .sysrst (sysrst), .paddr (paddr), .psel (psel), .penable (penable),
    .pwrite (pwrite), .pwdata (pwdata), .prdata (prdata), .pready (pready),
    .pslverr (pslverr), .txd (txd), .irq (irq)
  );

  always #4 HCLK = ~HCLK;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    return x ^ (x << 5);
  endfunction

  task automatic check_value(input logic [31:0] val, input logic [31:0] exp, input string what);
    assert (val === exp) else begin
      $display("ERROR %0t: %s is 0x%0h, expected 0x%0h", $time, what, val, exp);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == 0) pass_cnt++;
    else fail_cnt++;
    $display("%s: %s", (err_cnt == 0) ? "PASS" : "FAIL", name);
    err_cnt = 0;
  endtask

  // One APB transfer, setup then access
  task automatic apb_access(input logic wr, input logic [15:0] addr, input logic [31:0] wd,
                            output logic [31:0] rdata);
    int n;
    @(posedge HCLK);
    #1;
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = wd;
    @(posedge HCLK);
    #1 penable = 1'b1;
    #1 n = 0;
    while (!pready && n < 16) begin
      @(posedge HCLK);
      #2 n++;
    end
    if (!pready) begin
      $display("Timeout while waiting for pready at address 0x%0h", addr);
      err_cnt++;
    end
    rdata = prdata;
    last_err = pslverr;
    @(posedge HCLK);
    #1;
    psel = 1'b0;
    penable = 1'b0;
  endtask

  task automatic apb_write(input logic [15:0] addr, input logic [31:0] wd);
    logic [31:0] unused;
    apb_access(1'b1, addr, wd, unused);
  endtask

  task automatic apb_read(input logic [15:0] addr, output logic [31:0] rdata);
    apb_access(1'b0, addr, 32'd0, rdata);
  endtask

  task automatic poll_bit0(input logic [15:0] addr, input logic want, input string what);
    logic [31:0] val;
    int n;
    n = 0;
    val = {32{~want}};
    while (val[0] !== want && n < 60) begin
      apb_read(addr, val);
      n++;
    end
    if (val[0] !== want) begin
      $display("Timeout while waiting for %s", what);
      err_cnt++;
    end
  endtask

  task automatic wait_irq(input int bit_pos, input int limit);
    int n;
    n = 0;
    while (irq[bit_pos] !== 1'b1 && n < limit) begin
      @(posedge HCLK);
      #1 n++;
    end
    if (irq[bit_pos] !== 1'b1) begin
      $display("Timeout while waiting for irq bit %0d", bit_pos);
      err_cnt++;
    end
  endtask

  // Finds the start bit, then samples each bit in its middle
  task automatic capture_frame(output logic [7:0] data, output logic stop);
    int n;
    n = 0;
    while (txd !== 1'b0 && n < 200) begin
      @(posedge HCLK);
      #1 n++;
    end
    if (txd !== 1'b0) begin
      $display("Timeout while waiting for a UART start bit");
      err_cnt++;
    end
    repeat (baud_div / 2) @(posedge HCLK);
    #1 check_value(txd, 1'b0, "UART start bit");
    for (int i = 0; i < 8; i++) begin
      repeat (baud_div) @(posedge HCLK);
      #1 data[i] = txd;
    end
    repeat (baud_div) @(posedge HCLK);
    #1 stop = txd;
  endtask

  // ----------------------------------------
  // Tests
  // ----------------------------------------
  initial begin
    {HCLK, sysrst, psel, penable, pwrite, paddr, pwdata} = '0;
    {err_cnt, pass_cnt, fail_cnt} = '0;
    rng = 32'd2488;
    repeat (2) @(posedge HCLK);
    #1 sysrst = 1'b1;

    check_value(txd, 1'b1, "txd after reset");
    check_value(irq, 32'd0, "irq after reset");
    apb_read(timer_value_a, rd);
    check_value(rd, 32'd0, "timer value after reset");
    apb_read(timer_reload_a, rd);
    check_value(rd, 32'd0, "timer reload after reset");
    apb_read(uart_baud_a, rd);
    check_value(rd, 32'd16, "bauddiv after reset");
    end_test("reset values");

    apb_read(16'h5000, rd);
    check_value(last_err, 1'b1, "pslverr on unmapped read");
    check_value(rd, 32'd0, "prdata on unmapped read");
    apb_write(16'h5000, 32'hFFFF_FFFF);
    check_value(last_err, 1'b1, "pslverr on unmapped write");
    apb_read(timer_value_a, rd);
    check_value(last_err, 1'b0, "pslverr on timer read");
    apb_read(uart_baud_a, rd);
    check_value(last_err, 1'b0, "pslverr on UART read");
    end_test("address decode");

    apb_write(timer_reload_a, 32'h1234_5678);
    apb_write(timer_value_a, 32'h0000_ABCD);
    apb_read(timer_reload_a, rd);
    check_value(rd, 32'h1234_5678, "timer reload readback");
    apb_read(timer_value_a, rd);
    check_value(rd, 32'h0000_ABCD, "timer value readback");
    end_test("timer registers");

    apb_write(timer_reload_a, 32'd40);
    apb_write(timer_value_a, 32'd3);
    apb_write(timer_ctrl_a, 32'h9);              // Enable and irq enable
    wait_irq(8, 100);
    apb_write(timer_int_a, 32'd1);
    check_value(irq[8], 1'b0, "timer irq after clear");
    apb_write(timer_ctrl_a, 32'h1);              // Counting, irq masked
    poll_bit0(timer_int_a, 1'b1, "timer intstatus");
    check_value(irq[8], 1'b0, "masked timer irq");
    apb_write(timer_ctrl_a, 32'h0);
    apb_write(timer_int_a, 32'd1);
    end_test("timer interrupt");

    apb_write(uart_baud_a, baud_div);
    repeat (3) begin
      rng = xorshift(rng);
      b = rng[7:0];
      apb_write(uart_data_a, {24'd0, b});
      fork
        capture_frame(got, stop_bit);
        begin
          apb_read(uart_state_a, rd);
          check_value(rd[0], 1'b1, "UART busy during frame");
        end
      join
      check_value(got, b, "UART data bits");
      check_value(stop_bit, 1'b1, "UART stop bit");
      poll_bit0(uart_state_a, 1'b0, "UART idle");
    end
    end_test("UART frames");

    apb_write(uart_int_a, 32'd1);                // Left set by earlier frames
    apb_write(uart_ctrl_a, 32'h4);
    check_value(irq[1], 1'b0, "tx irq before frame");
    rng = xorshift(rng);
    b = rng[7:0];
    apb_write(uart_data_a, {24'd0, b});
    fork
      capture_frame(got, stop_bit);
      apb_write(uart_data_a, {24'd0, ~b});       // Must be ignored while busy
    join
    check_value(got, b, "UART byte with write while busy");
    check_value(stop_bit, 1'b1, "UART stop bit");
    wait_irq(1, 100);
    apb_write(uart_int_a, 32'd1);
    check_value(irq[1], 1'b0, "tx irq after clear");
    end_test("UART interrupt");

    $display("Tests passed: %0d, failed: %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0 && u_mcu_periph_top.u_mcu_periph_asserts.violations == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* mcu_periph_top.f */
source/apb_bus_pkg.sv
source/periph_regs_pkg.sv
source/apb_slot_if.sv
source/apb_slot_decoder.sv
source/apb_timer.sv
source/apb_uart_tx.sv
source/mcu_periph_top.sv
verification/mcu_periph_asserts.sv
verification/mcu_periph_tb.sv

/* Bender.yml */
package:
  name: mcu_periph

sources:
  - source/apb_bus_pkg.sv
  - source/periph_regs_pkg.sv
  - source/apb_slot_if.sv
  - source/apb_slot_decoder.sv
  - source/apb_timer.sv
  - source/apb_uart_tx.sv
  - source/mcu_periph_top.sv
  - target: test
    files:
      - verification/mcu_periph_asserts.sv
      - verification/mcu_periph_tb.sv
